// File: design/frontend_defines.svh
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

////////////////////
// fetch addresses
////////////////////

// first fetch after reset
`define FE_RESET_PC 32'h0000_0100

// rom word address width, 256 words
`define FE_ROM_AW 8

////////////////////
// buffering
////////////////////

// fetch queue entries
`define FE_QUEUE_DEPTH 8

////////////////////
// exception causes
////////////////////

// no exception on this fetch
`define EXC_NOP 6'h3f
// pending interrupt, loongarch ecode 0x0
`define EXC_INT 6'h00
// fetch address error, loongarch ecode 0x8
`define EXC_ADEF 6'h08

`endif

// File: design/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    ////////////////////
    // plain vectors
    ////////////////////

    // byte address of an instruction
    typedef logic [31:0] inst_addr_t;
    // raw instruction bits
    typedef logic [31:0] inst_word_t;
    // exception cause, estat.ecode width
    typedef logic [5:0] exc_code_t;

    ////////////////////
    // bundles
    ////////////////////

    // request from pc_gen to the rom
    typedef struct packed {
        logic       valid;
        inst_addr_t pc;
        exc_code_t  exc;
    } fetch_req_t;

    // one fetched instruction with its tag
    typedef struct packed {
        inst_addr_t pc;
        inst_word_t inst;
        exc_code_t  exc;
    } fetch_entry_t;

    // predicted-taken redirect back to pc_gen
    typedef struct packed {
        logic       valid;
        inst_addr_t target;
    } redirect_t;

    // pc_gen start-up fsm
    typedef enum logic {
        PC_RESET,
        PC_RUN
    } pc_state_t;

endpackage

`default_nettype wire

// File: design/pc_gen.sv
`default_nettype none
`include "frontend_defines.svh"

module pc_gen
    import frontend_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       is_interrupt,
    input  logic       exception_flush,
    input  logic       branch_flush,
    input  logic       fetch_pause,
    input  inst_addr_t exception_new_pc,
    input  inst_addr_t branch_actual_addr,
    input  redirect_t  predict_redir,
    output fetch_req_t fetch_req
);

    pc_state_t  state;
    inst_addr_t pc_next;
    logic       valid_next;
    exc_code_t  exc_next;

    ////////////////////
    // next fetch address
    ////////////////////

    // fetch_req.pc doubles as the pc register
    always_comb begin
        pc_next    = fetch_req.pc;
        valid_next = 1'b1;
        if (exception_flush) begin
            pc_next = exception_new_pc;
        end else if (branch_flush) begin
            pc_next = branch_actual_addr;
        end else if (predict_redir.valid) begin
            pc_next = predict_redir.target;
        end else if (state == PC_RESET) begin
            // reset pc goes out after one idle cycle
            pc_next = `FE_RESET_PC;
        end else if (fetch_pause) begin
            // hold while the queue is near full
            valid_next = 1'b0;
        end else begin
            pc_next = fetch_req.pc + 32'd4;
        end
    end

    // misaligned address beats interrupt
    always_comb begin
        if (pc_next[1:0] != 2'b00) begin
            exc_next = `EXC_ADEF;
        end else if (is_interrupt) begin
            exc_next = `EXC_INT;
        end else begin
            exc_next = `EXC_NOP;
        end
    end

    ////////////////////
    // request register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= PC_RESET;
            fetch_req.valid <= 1'b0;
            fetch_req.pc    <= `FE_RESET_PC;
            fetch_req.exc   <= `EXC_NOP;
        end else begin
            state           <= PC_RUN;
            fetch_req.valid <= valid_next;
            fetch_req.pc    <= pc_next;
            fetch_req.exc   <= exc_next;
        end
    end

    // only untagged b / bl are predicted, so their targets stay word aligned
    a_redir_aligned: assert property (@(posedge clk) disable iff (rst)
        predict_redir.valid |-> predict_redir.target[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: design/inst_rom.sv
`default_nettype none
`include "frontend_defines.svh"

module inst_rom
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  rom_we,
    input  logic [`FE_ROM_AW-1:0] rom_waddr,
    input  inst_word_t            rom_wdata,
    input  fetch_req_t            fetch_req,
    output fetch_entry_t          rom_entry,
    output logic                  rom_entry_valid
);

    localparam int ROM_WORDS = 1 << `FE_ROM_AW;

    inst_word_t            mem [ROM_WORDS];
    logic [`FE_ROM_AW-1:0] rd_idx;

    // word index, byte offset dropped
    assign rd_idx = fetch_req.pc[`FE_ROM_AW+1:2];

    // load port, driven while the core is held in reset
    always_ff @(posedge clk) begin
        if (rom_we) begin
            mem[rom_waddr] <= rom_wdata;
        end
    end

    ////////////////////
    // registered read
    ////////////////////

    always_ff @(posedge clk) begin
        rom_entry.pc  <= fetch_req.pc;
        rom_entry.exc <= fetch_req.exc;
        // bad address fetches nothing
        if (fetch_req.exc == `EXC_ADEF) begin
            rom_entry.inst <= '0;
        end else begin
            rom_entry.inst <= mem[rd_idx];
        end
    end

    // request caught by a flush is dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_entry_valid <= 1'b0;
        end else begin
            rom_entry_valid <= fetch_req.valid && !flush;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_queue.sv
`default_nettype none
`include "frontend_defines.svh"

module fetch_queue
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  fetch_entry_t rom_entry,
    input  logic         rom_entry_valid,
    input  logic         pop,
    output fetch_entry_t head_entry,
    output logic         head_valid,
    output logic         fetch_pause
);

    localparam int DEPTH = `FE_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    localparam logic [PW-1:0] PTR_LAST    = PW'(DEPTH - 1);
    localparam logic [PW:0]   FULL_LEVEL  = (PW+1)'(DEPTH);
    // room left for the rom output and the pending request
    localparam logic [PW:0]   PAUSE_LEVEL = (PW+1)'(DEPTH - 2);

    fetch_entry_t  mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          wr_en;
    logic          rd_en;

    // wrong-path entry arriving with a flush is not stored
    assign wr_en = rom_entry_valid && !flush;
    assign rd_en = pop;

    ////////////////////
    // head and status
    ////////////////////

    assign head_entry = mem[rd_ptr];
    // stale head is hidden while flushing
    assign head_valid  = (count != '0) && !flush;
    assign fetch_pause = count >= PAUSE_LEVEL;

    // entry storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rom_entry;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // early pause in pc_gen must keep the queue from overflowing
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> count != FULL_LEVEL);

    // consumer only pops a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> count != '0);

endmodule

`default_nettype wire

// File: design/branch_predecode.sv
`default_nettype none
`include "frontend_defines.svh"

module branch_predecode
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         issue_stall,
    input  fetch_entry_t head_entry,
    input  logic         head_valid,
    output logic         pop,
    output fetch_entry_t issue_entry,
    output logic         issue_valid,
    output redirect_t    predict_redir
);

    logic        out_valid;
    logic        is_direct_br;
    logic [25:0] offs26;
    inst_addr_t  br_target;

    assign pop = head_valid && !issue_stall;

    ////////////////////
    // b / bl decode
    ////////////////////

    // opcode 010100 is b, 010101 is bl
    assign is_direct_br = (head_entry.inst[31:27] == 5'b01010) &&
                          (head_entry.exc == `EXC_NOP);

    // offs26 is split, low half sits above the high half
    assign offs26    = {head_entry.inst[9:0], head_entry.inst[25:10]};
    assign br_target = head_entry.pc + {{4{offs26[25]}}, offs26, 2'b00};

    ////////////////////
    // issue register
    ////////////////////

    // held entry shows only once the stall drops
    assign issue_valid = out_valid && !issue_stall;

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_entry          <= head_entry;
            predict_redir.target <= br_target;
        end
        if (rst) begin
            out_valid           <= 1'b0;
            predict_redir.valid <= 1'b0;
        end else begin
            // always taken, one pulse per popped branch
            predict_redir.valid <= pop && is_direct_br;
            if (!issue_stall) begin
                out_valid <= head_valid;
            end
        end
    end

    // the redirect flushes the queue, so the next head cannot pop
    a_redir_single: assert property (@(posedge clk) disable iff (rst)
        predict_redir.valid |=> !predict_redir.valid);

endmodule

`default_nettype wire

// File: design/frontend_top.sv
`default_nettype none
`include "frontend_defines.svh"

module frontend_top
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rom_we,
    input  logic [`FE_ROM_AW-1:0] rom_waddr,
    input  inst_word_t            rom_wdata,
    input  logic                  is_interrupt,
    input  logic                  exception_flush,
    input  inst_addr_t            exception_new_pc,
    input  logic                  branch_flush,
    input  inst_addr_t            branch_actual_addr,
    input  logic                  issue_stall,
    output logic                  issue_valid,
    output fetch_entry_t          issue_entry
);

    fetch_req_t   fetch_req;
    fetch_entry_t rom_entry;
    logic         rom_entry_valid;
    fetch_entry_t head_entry;
    logic         head_valid;
    logic         fetch_pause;
    logic         pop;
    redirect_t    predict_redir;
    logic         kill;

    // any redirect kills everything between pc_gen and issue
    assign kill = exception_flush || branch_flush || predict_redir.valid;

    pc_gen i_pc_gen (
        .clk                (clk),
        .rst                (rst),
        .is_interrupt       (is_interrupt),
        .exception_flush    (exception_flush),
        .branch_flush       (branch_flush),
        .fetch_pause        (fetch_pause),
        .exception_new_pc   (exception_new_pc),
        .branch_actual_addr (branch_actual_addr),
        .predict_redir      (predict_redir),
        .fetch_req          (fetch_req)
    );

    inst_rom i_inst_rom (
        .clk             (clk),
        .rst             (rst),
        .flush           (kill),
        .rom_we          (rom_we),
        .rom_waddr       (rom_waddr),
        .rom_wdata       (rom_wdata),
        .fetch_req       (fetch_req),
        .rom_entry       (rom_entry),
        .rom_entry_valid (rom_entry_valid)
    );

    fetch_queue i_fetch_queue (
        .clk             (clk),
        .rst             (rst),
        .flush           (kill),
        .rom_entry       (rom_entry),
        .rom_entry_valid (rom_entry_valid),
        .pop             (pop),
        .head_entry      (head_entry),
        .head_valid      (head_valid),
        .fetch_pause     (fetch_pause)
    );

    branch_predecode i_branch_predecode (
        .clk           (clk),
        .rst           (rst),
        .issue_stall   (issue_stall),
        .head_entry    (head_entry),
        .head_valid    (head_valid),
        .pop           (pop),
        .issue_entry   (issue_entry),
        .issue_valid   (issue_valid),
        .predict_redir (predict_redir)
    );

endmodule

`default_nettype wire

// File: sim/frontend_tb.sv
`default_nettype none
`include "frontend_defines.svh"

module frontend_tb
    import frontend_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROM_WORDS    = 1 << `FE_ROM_AW;
    localparam int RESET_CYCLES = 4;
    localparam int N_CYCLES     = 4000;
    localparam int DRAIN_CYCLES = 60;
    // deliveries after an irq edge before the tag must be exact
    localparam int IRQ_GUARD    = 12;
    localparam int TIMEOUT_NS   =
        (ROM_WORDS + RESET_CYCLES + N_CYCLES + DRAIN_CYCLES) * 20 + 2000;

    logic                  clk;
    logic                  rst;
    logic                  rom_we;
    logic [`FE_ROM_AW-1:0] rom_waddr;
    inst_word_t            rom_wdata;
    logic                  is_interrupt;
    logic                  exception_flush;
    inst_addr_t            exception_new_pc;
    logic                  branch_flush;
    inst_addr_t            branch_actual_addr;
    logic                  issue_stall;
    logic                  issue_valid;
    fetch_entry_t          issue_entry;

    // reference copy of the rom and fetch stream state
    inst_word_t rom_model [ROM_WORDS];
    int         seed       = 32'h80a08805;
    inst_addr_t expect_pc  = `FE_RESET_PC;
    logic       irq_seen   = 1'b0;
    int         since_irq  = 100;
    int         deliveries = 0;
    int         long_stall = 0;
    int         irq_left   = 80;

    frontend_top i_frontend_top (
        .clk                (clk),
        .rst                (rst),
        .rom_we             (rom_we),
        .rom_waddr          (rom_waddr),
        .rom_wdata          (rom_wdata),
        .is_interrupt       (is_interrupt),
        .exception_flush    (exception_flush),
        .exception_new_pc   (exception_new_pc),
        .branch_flush       (branch_flush),
        .branch_actual_addr (branch_actual_addr),
        .issue_stall        (issue_stall),
        .issue_valid        (issue_valid),
        .issue_entry        (issue_entry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // random word with roughly one in eight turned into b or bl
    function automatic inst_word_t make_word();
        inst_word_t  w;
        logic [31:0] r;
        w = next_rand();
        r = next_rand();
        if (r[2:0] == 3'b000) begin
            w[31:26] = {5'b01010, r[3]};
        end
        return w;
    endfunction

    // flush target with about one in sixteen misaligned
    function automatic inst_addr_t make_target();
        logic [31:0] r;
        inst_addr_t  a;
        r = next_rand();
        a = next_rand();
        if (r[3:0] != 4'h0) begin
            a[1:0] = 2'b00;
        end else if (a[1:0] == 2'b00) begin
            a[1:0] = 2'b10;
        end
        return a;
    endfunction

    function automatic logic is_direct_branch(input inst_word_t inst);
        return inst[31:26] == 6'b010100 || inst[31:26] == 6'b010101;
    endfunction

    // offs26 is inst[9:0] over inst[25:10] in words
    function automatic inst_addr_t branch_target(input inst_addr_t pc, input inst_word_t inst);
        logic signed [25:0] offs;
        int                 byte_offs;
        offs      = {inst[9:0], inst[25:10]};
        byte_offs = int'(offs) * 4;
        return pc + inst_addr_t'(byte_offs);
    endfunction

    function automatic inst_word_t expected_inst(input inst_addr_t pc);
        if (pc[1:0] != 2'b00) begin
            return '0;
        end
        return rom_model[pc[`FE_ROM_AW+1:2]];
    endfunction

    // misaligned beats interrupt
    // near an irq edge both tags are legal
    function automatic exc_code_t expected_exc(input inst_addr_t pc, input exc_code_t got);
        if (pc[1:0] != 2'b00) begin
            return `EXC_ADEF;
        end
        if (since_irq > IRQ_GUARD) begin
            return is_interrupt ? `EXC_INT : `EXC_NOP;
        end
        if (got == `EXC_INT) begin
            return `EXC_INT;
        end
        return `EXC_NOP;
    endfunction

    // one cycle of random stall, flush and interrupt stimulus
    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] r2;
        logic        exc_pulse;
        logic        br_pulse;
        logic        stall;
        r         = next_rand();
        exc_pulse = r[5:0] == 6'd0;
        br_pulse  = r[11:7] == 5'd0;
        if (long_stall > 0) begin
            stall      = 1'b1;
            long_stall = long_stall - 1;
        end else if (r[23:16] == 8'd0) begin
            // long stall fills the queue up to the pause level
            stall      = 1'b1;
            long_stall = 20 + int'(r[29:25]);
        end else begin
            stall = r[15:12] < 4'd5;
        end
        // issue register drains in the flush cycle
        if (exc_pulse || br_pulse) begin
            stall = 1'b0;
        end
        if (irq_left == 0) begin
            r2           = next_rand();
            is_interrupt <= ~is_interrupt;
            irq_left     = 40 + int'(r2[7:0]);
        end else begin
            irq_left = irq_left - 1;
        end
        exception_flush    <= exc_pulse;
        branch_flush       <= br_pulse;
        exception_new_pc   <= make_target();
        branch_actual_addr <= make_target();
        issue_stall        <= stall;
    endtask

    ////////////////////
    // fetch stream model
    ////////////////////

    // outputs settle after the rising edge and are sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (is_interrupt != irq_seen) begin
                irq_seen  = is_interrupt;
                since_irq = 0;
            end
            if (issue_stall) begin
                check_value("issue_valid", {31'b0, issue_valid}, 32'h0);
            end
            if (issue_valid) begin
                since_irq  = since_irq + 1;
                deliveries = deliveries + 1;
                check_value("issue_entry.pc", issue_entry.pc, expect_pc);
                check_value("issue_entry.inst", issue_entry.inst, expected_inst(expect_pc));
                check_value("issue_entry.exc", {26'b0, issue_entry.exc},
                            {26'b0, expected_exc(expect_pc, issue_entry.exc)});
                // always-taken prediction only for untagged b / bl
                if (is_direct_branch(issue_entry.inst) && issue_entry.exc == `EXC_NOP) begin
                    expect_pc = branch_target(expect_pc, issue_entry.inst);
                end else begin
                    expect_pc = expect_pc + 32'd4;
                end
            end
            // exception flush wins when both pulse
            if (exception_flush) begin
                expect_pc = exception_new_pc;
            end else if (branch_flush) begin
                expect_pc = branch_actual_addr;
            end
        end
    end

    ////////////////////
    // sequence
    ////////////////////

    initial begin
        inst_word_t w;
        rst                = 1'b1;
        rom_we             = 1'b0;
        rom_waddr          = '0;
        rom_wdata          = '0;
        is_interrupt       = 1'b0;
        exception_flush    = 1'b0;
        exception_new_pc   = '0;
        branch_flush       = 1'b0;
        branch_actual_addr = '0;
        issue_stall        = 1'b0;

        // rom load under reset at one word per cycle
        for (int i = 0; i < ROM_WORDS; i++) begin
            @(posedge clk);
            w            = make_word();
            rom_model[i] = w;
            rom_we       <= 1'b1;
            rom_waddr    <= i[`FE_ROM_AW-1:0];
            rom_wdata    <= w;
        end
        @(posedge clk);
        rom_we <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst <= 1'b0;

        for (int c = 0; c < N_CYCLES; c++) begin
            @(posedge clk);
            drive_cycle();
        end

        // quiet tail so the queue drains
        @(posedge clk);
        exception_flush <= 1'b0;
        branch_flush    <= 1'b0;
        issue_stall     <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);

        if (deliveries < N_CYCLES / 10) begin
            $display("only %0d instructions reached issue, fetch made too little progress",
                     deliveries);
            $display("tests failed");
            $fatal(1);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/frontend_pkg.sv
design/pc_gen.sv
design/inst_rom.sv
design/fetch_queue.sv
design/branch_predecode.sv
design/frontend_top.sv
sim/frontend_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f vlog.f -o frontend_sim || exit 1
out=$(./obj_dir/frontend_sim)
echo "$out"
echo "$out" | grep -q "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
